// ==== list.f ====
+incdir+.
esp_link_pkg.sv
spi_byte_slave.sv
cmd_parser.sv
breakpoint_unit.sv
esp_link_top.sv
esp_link_props.sv
tb_esp_link.sv

// ==== Makefile ====
TOP := tb_esp_link

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_esp_link.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "esp_link_defs.svh"

module tb_esp_link;

  import esp_link_pkg::*;

  logic                 clk;
  logic                 rst_button;
  logic                 cs_n;
  logic                 sck;
  logic                 mosi;
  logic [15:0]          bus_addr;
  logic                 bus_rd_n;
  logic                 miso;
  logic                 stop_out;
  logic [`BP_IDX_W-1:0] idx_out;

  integer     seed;
  integer     rnd;
  int         checks;
  int         mismatches;
  int         timeouts;
  int         wait_n;
  logic [8:0] exp_q[$];  // expected, reply as {0, byte} or {stop, 0, index}
  logic [8:0] act_q[$];
  string      what_q[$];
  logic [2:0]  slot_a;
  logic [2:0]  slot_b;
  logic [15:0] addr_a;

  // slot table model
  logic [15:0]                 model_addr [`NUM_BREAKPOINTS];
  logic [`NUM_BREAKPOINTS-1:0] model_active;
  logic                        model_enabled;
  logic                        model_stopped;
  logic [`BP_IDX_W-1:0]        model_index;

  esp_link_top i_dut (
    .clk        (clk),
    .rst_button (rst_button),
    .cs_n       (cs_n),
    .sck        (sck),
    .mosi       (mosi),
    .bus_addr   (bus_addr),
    .bus_rd_n   (bus_rd_n),
    .miso       (miso),
    .xray_stop  (stop_out),
    .bp_index   (idx_out)
  );

  always #2 clk = ~clk; // 4 ns period

  // expected reply byte, or stop state after a bus read of addr
  function automatic logic [8:0] predict(input logic bus_read, input logic [7:0] op,
                                         input logic [15:0] addr);
    logic [8:0] res;
    logic       found;
    res   = {model_stopped, 5'b0, model_index};
    found = 1'b0;
    if (!bus_read) begin
      case (op)
        get_cookie:  res = {1'b0, 8'haf};
        get_version: res = {1'b0, 8'h03}; // major 0, minor 3
        abus_read:   res = {1'b0, addr[7:0]};
        default:     res = '0;
      endcase
    end else if (!model_stopped && model_enabled) begin
      for (int i = 0; i < `NUM_BREAKPOINTS; i++) begin
        if (!found && model_active[i] && (model_addr[i] == addr)) begin
          found = 1'b1; // first match is the lowest slot
          res   = {1'b1, 5'b0, i[`BP_IDX_W-1:0]};
        end
      end
    end
    return res;
  endfunction

  task automatic push(input logic [8:0] e, input logic [8:0] a, input string what);
    exp_q.push_back(e);
    act_q.push_back(a);
    what_q.push_back(what);
  endtask

  // one byte each way, mosi changes while sck low
  task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int b = 7; b >= 0; b--) begin
      sck  = 1'b0;
      mosi = tx[b];
      repeat (8) @(negedge clk);
      sck   = 1'b1;
      rx[b] = miso; // settled during the low phase
      repeat (8) @(negedge clk);
    end
  endtask

  task automatic end_frame();
    sck = 1'b0; // trailing fall
    repeat (8) @(negedge clk);
    cs_n = 1'b1;
    repeat (8) @(negedge clk);
  endtask

  // opcode then a dummy byte to clock out the reply
  task automatic query(input logic [7:0] op, input string what);
    logic [7:0] dummy;
    logic [7:0] got;
    cs_n = 1'b0;
    repeat (8) @(negedge clk);
    xfer_byte(op, dummy);
    xfer_byte(8'h00, got);
    end_frame();
    push(predict(1'b0, op, bus_addr), {1'b0, got}, what);
  endtask

  // params go out low byte first
  task automatic command(input logic [7:0] op, input int nbytes, input logic [23:0] params);
    logic [7:0] dummy;
    cs_n = 1'b0;
    repeat (8) @(negedge clk);
    xfer_byte(op, dummy);
    for (int k = 0; k < nbytes; k++) begin
      xfer_byte(params[8*k +: 8], dummy);
    end
    end_frame();
    case (op) // model follows the command
      set_breakpoint: begin
        model_addr[params[2:0]]   = params[23:8];
        model_active[params[2:0]] = 1'b1;
      end
      clear_breakpoint:    model_active[params[2:0]] = 1'b0;
      enable_breakpoints:  model_enabled = 1'b1;
      disable_breakpoints: model_enabled = 1'b0;
      xray_resume:         model_stopped = 1'b0;
      default: begin
      end
    endcase
  endtask

  task automatic set_slot(input logic [2:0] slot, input logic [15:0] addr);
    command(set_breakpoint, 3, {addr, 5'b0, slot});
  endtask

  task automatic check_state(input string what);
    push({model_stopped, 5'b0, model_index}, {stop_out, 5'b0, idx_out}, what);
  endtask

  task automatic bus_read(input logic [15:0] addr, input string what);
    logic [8:0] exp;
    int         n;
    exp      = predict(1'b1, 8'h00, addr);
    bus_addr = addr;
    repeat (6) @(negedge clk); // address setup before the strobe
    bus_rd_n = 1'b0;
    n        = 0;
    // poll for a due stop, else watch the whole window
    while ((n < 10) && !(exp[8] && stop_out)) begin
      @(negedge clk);
      n++;
    end
    if (exp[8] && !stop_out) begin
      $display("timeout at %0t: xray_stop did not rise for %s", $time, what);
      timeouts++;
    end
    push(exp, {stop_out, 5'b0, idx_out}, what);
    bus_rd_n = 1'b1;
    repeat (4) @(negedge clk);
    model_stopped = exp[8];
    model_index   = exp[2:0];
  endtask

  // compares whatever the stimulus has queued
  always @(posedge clk) begin : compare
    logic [8:0] e;
    logic [8:0] a;
    string      w;
    while (act_q.size() > 0) begin
      e = exp_q.pop_front();
      a = act_q.pop_front();
      w = what_q.pop_front();
      checks++;
      if (e !== a) begin
        mismatches++;
        $display("mismatch at %0t: %s expected %h got %h", $time, w, e, a);
      end
    end
  end

  initial begin
    seed          = 51895;
    clk           = 1'b0;
    rst_button    = 1'b1;
    cs_n          = 1'b1;
    sck           = 1'b0;
    mosi          = 1'b0;
    bus_addr      = '0;
    bus_rd_n      = 1'b1;
    checks        = 0;
    mismatches    = 0;
    timeouts      = 0;
    model_active  = '0;
    model_enabled = 1'b0;
    model_stopped = 1'b0;
    model_index   = '0;
    repeat (4) @(negedge clk);
    rst_button = 1'b0;
    @(negedge clk);
    check_state("state after reset");
    cs_n = 1'b0; // selected, so miso shows the reply shifter
    @(negedge clk);
    push(9'd0, {8'd0, miso}, "miso after reset");
    cs_n = 1'b1;
    repeat (8) @(negedge clk);

    query(get_cookie, "cookie");
    query(get_version, "version");
    rnd      = $random(seed);
    bus_addr = rnd[15:0];
    query(abus_read, "abus_read low byte");

    // single slot
    rnd    = $random(seed);
    slot_a = rnd[2:0];
    addr_a = rnd[31:16];
    set_slot(slot_a, addr_a);
    command(enable_breakpoints, 0, '0);
    bus_read(addr_a ^ 16'h8001, "read of other address");
    bus_read(addr_a, "read of slot address");
    command(xray_resume, 0, '0);
    check_state("after resume");

    // two slots on one address, lower index wins
    command(clear_breakpoint, 1, {16'h0, 5'b0, slot_a});
    rnd    = $random(seed);
    slot_a = rnd[2:0];
    slot_b = rnd[2:0] ^ (rnd[6:4] | 3'd1); // never equal to slot_a
    addr_a = rnd[31:16];
    set_slot(slot_b, addr_a);
    set_slot(slot_a, addr_a);
    bus_read(addr_a, "two slots same address");
    command(xray_resume, 0, '0);
    command(clear_breakpoint, 1, {16'h0, 5'b0, ((slot_a < slot_b) ? slot_a : slot_b)});
    bus_read(addr_a, "lower slot cleared");
    command(xray_resume, 0, '0);
    command(clear_breakpoint, 1, {16'h0, 5'b0, ((slot_a < slot_b) ? slot_b : slot_a)});
    bus_read(addr_a, "both slots cleared");

    // disable blocks new stops but keeps a held one
    set_slot(slot_b, addr_a);
    bus_read(addr_a, "slot set again");
    command(disable_breakpoints, 0, '0);
    check_state("stop held over disable");
    command(xray_resume, 0, '0);
    bus_read(addr_a, "read while disabled");

    command(8'h50, 0, '0); // not a known opcode
    query(get_cookie, "cookie after unknown opcode");

    wait_n = 0;
    while ((act_q.size() > 0) && (wait_n < 100)) begin
      @(negedge clk);
      wait_n++;
    end
    if (act_q.size() > 0) begin
      $display("timeout at %0t: compare queue did not drain", $time);
      timeouts++;
    end
    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    if ((mismatches == 0) && (timeouts == 0)) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog for a stuck run
  initial begin
    repeat (200000) @(posedge clk);
    $display("timeout: test did not reach its end");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== esp_link_props.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "esp_link_defs.svh"

module esp_link_props (
  input logic                 clk,
  input logic                 rst_button,
  input logic                 cs_n,
  input logic                 miso,
  input logic                 bus_rd_n,
  input logic                 xray_stop,
  input logic [`BP_IDX_W-1:0] bp_index
);

  // deselected slave keeps miso low
  miso_idle: assert property (@(posedge clk) disable iff (rst_button)
    cs_n |-> !miso)
    else $error("miso high while cs_n high");

  // index frozen while stopped, resume included
  index_hold: assert property (@(posedge clk) disable iff (rst_button)
    $past(xray_stop) |-> $stable(bp_index))
    else $error("bp_index changed during stop");

  // stop needs a synchronised read, three samples back
  stop_after_read: assert property (@(posedge clk) disable iff (rst_button)
    $rose(xray_stop) |-> ($past(bus_rd_n, 3) == 1'b0))
    else $error("xray_stop rose without a bus read");

endmodule

bind esp_link_top esp_link_props i_props (
  .clk        (clk),
  .rst_button (rst_button),
  .cs_n       (cs_n),
  .miso       (miso),
  .bus_rd_n   (bus_rd_n),
  .xray_stop  (xray_stop),
  .bp_index   (bp_index)
);

`default_nettype wire

// ==== esp_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "esp_link_defs.svh"

module esp_link_top (
  input  logic                 clk,
  input  logic                 rst_button,
  input  logic                 cs_n,
  input  logic                 sck,
  input  logic                 mosi,
  input  logic [15:0]          bus_addr,
  input  logic                 bus_rd_n,
  output logic                 miso,
  output logic                 xray_stop,
  output logic [`BP_IDX_W-1:0] bp_index
);

  import esp_link_pkg::*;

  logic [7:0] rx_byte;
  logic       rx_valid;
  logic [7:0] reply_byte;
  logic       reply_load;
  logic       cmd_strobe;  // one cycle per accepted command
  esp_cmd_t   cmd_op;
  logic [7:0] p0;
  logic [7:0] p1;
  logic [7:0] p2;

  // byte channel from the wifi controller
  spi_byte_slave i_spi (
    .clk        (clk),
    .rst_button (rst_button),
    .cs_n       (cs_n),
    .sck        (sck),
    .mosi       (mosi),
    .miso       (miso),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .reply_byte (reply_byte),
    .reply_load (reply_load)
  );

  cmd_parser i_parser (
    .clk        (clk),
    .rst_button (rst_button),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .bus_addr   (bus_addr),
    .reply_byte (reply_byte),
    .reply_load (reply_load),
    .cmd_strobe (cmd_strobe),
    .cmd_op     (cmd_op),
    .p0         (p0),
    .p1         (p1),
    .p2         (p2)
  );

  // watches bus reads against the slot table
  breakpoint_unit i_bp (
    .clk        (clk),
    .rst_button (rst_button),
    .cmd_strobe (cmd_strobe),
    .cmd_op     (cmd_op),
    .p0         (p0),
    .p1         (p1),
    .p2         (p2),
    .bus_addr   (bus_addr),
    .bus_rd_n   (bus_rd_n),
    .xray_stop  (xray_stop),
    .bp_index   (bp_index)
  );

endmodule

`default_nettype wire

// ==== breakpoint_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "esp_link_defs.svh"

module breakpoint_unit (
  input  logic                   clk,
  input  logic                   rst_button,
  input  logic                   cmd_strobe,
  input  esp_link_pkg::esp_cmd_t cmd_op,
  input  logic [7:0]             p0,
  input  logic [7:0]             p1,
  input  logic [7:0]             p2,
  input  logic [15:0]            bus_addr,
  input  logic                   bus_rd_n,
  output logic                   xray_stop,
  output logic [`BP_IDX_W-1:0]   bp_index
);

  import esp_link_pkg::*;

  localparam int IDX_W = `BP_IDX_W;

  logic [15:0]                 slot_addr [`NUM_BREAKPOINTS];
  logic [`NUM_BREAKPOINTS-1:0] slot_active;
  logic                        bp_enabled;  // global enable
  xray_state_t                 run_state;
  logic [2:0]                  rd_sync;     // read strobe synchroniser
  logic                        rd_fall;
  logic [IDX_W-1:0]            slot_sel;
  logic                        hit;
  logic [IDX_W-1:0]            hit_idx;

  assign slot_sel = p0[IDX_W-1:0]; // p0 & 7

  always_ff @(posedge clk or posedge rst_button) begin
    if (rst_button) begin
      rd_sync <= '1; // bus idle high
    end else begin
      rd_sync <= {rd_sync[1:0], bus_rd_n};
    end
  end

  assign rd_fall = (rd_sync[2:1] == 2'b10);

  // lowest active slot wins, so scan from the top down
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = `NUM_BREAKPOINTS - 1; i >= 0; i--) begin
      if (slot_active[i] && (slot_addr[i] == bus_addr)) begin
        hit     = 1'b1;
        hit_idx = IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk or posedge rst_button) begin
    if (rst_button) begin
      slot_active <= '0;
      bp_enabled  <= 1'b0;
      run_state   <= xray_run;
      bp_index    <= '0;
    end else begin
      if (cmd_strobe) begin
        case (cmd_op)
          set_breakpoint:      slot_active[slot_sel] <= 1'b1;
          clear_breakpoint:    slot_active[slot_sel] <= 1'b0;
          enable_breakpoints:  bp_enabled <= 1'b1;
          disable_breakpoints: bp_enabled <= 1'b0; // a stop stays
          xray_resume:         run_state <= xray_run;
          default: begin
          end
        endcase
      end
      // port name hides the enum literal here
      if (rd_fall && bp_enabled && (run_state == xray_run) && hit) begin
        run_state <= esp_link_pkg::xray_stop;
        bp_index  <= hit_idx; // held until the next stop
      end
    end
  end

  // slot addresses, {hi, lo}
  always_ff @(posedge clk) begin
    if (cmd_strobe && (cmd_op == set_breakpoint)) begin
      slot_addr[slot_sel] <= {p2, p1};
    end
  end

  assign xray_stop = (run_state != xray_run);

endmodule

`default_nettype wire

// ==== cmd_parser.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "esp_link_defs.svh"

module cmd_parser (
  input  logic                   clk,
  input  logic                   rst_button,
  input  logic [7:0]             rx_byte,
  input  logic                   rx_valid,
  input  logic [15:0]            bus_addr,
  output logic [7:0]             reply_byte,
  output logic                   reply_load,
  output logic                   cmd_strobe,
  output esp_link_pkg::esp_cmd_t cmd_op,
  output logic [7:0]             p0,
  output logic [7:0]             p1,
  output logic [7:0]             p2
);

  import esp_link_pkg::*;

  localparam int CNT_W = $clog2(`MAX_PARAMS + 1);

  parser_state_t    state_q;
  logic [CNT_W-1:0] bytes_left;           // parameter bytes still expected
  logic [CNT_W-1:0] idx;                  // next parameter slot
  logic [7:0]       params [`MAX_PARAMS];
  logic             op_known;
  logic             op_replies;           // command answers with one byte
  logic [CNT_W-1:0] op_nparams;
  logic [7:0]       reply_next;
  logic             take_param;
  logic             take_reply;

  // opcode decode, looked at only in idle
  always_comb begin
    op_known   = 1'b1;
    op_replies = 1'b0;
    op_nparams = '0;
    reply_next = `ESP_COOKIE;
    case (rx_byte)
      get_cookie: begin
        op_replies = 1'b1;
      end
      get_version: begin
        op_replies = 1'b1;
        reply_next = {`VERSION_MAJOR, `VERSION_MINOR};
      end
      abus_read: begin
        op_replies = 1'b1;
        reply_next = bus_addr[7:0]; // sampled with the strobe
      end
      set_breakpoint: begin
        op_nparams = CNT_W'(`MAX_PARAMS);
      end
      clear_breakpoint: begin
        op_nparams = CNT_W'(1);
      end
      enable_breakpoints, disable_breakpoints, xray_resume: begin
        op_known = 1'b1; // no parameters, no reply
      end
      default: begin
        op_known = 1'b0; // unknown opcode, dropped
      end
    endcase
  end

  // command FSM
  always_ff @(posedge clk or posedge rst_button) begin
    if (rst_button) begin
      state_q    <= idle;
      bytes_left <= '0;
      idx        <= '0;
      cmd_op     <= get_cookie;
      cmd_strobe <= 1'b0;
      reply_load <= 1'b0;
    end else begin
      cmd_strobe <= 1'b0;
      reply_load <= 1'b0;
      if (rx_valid) begin
        case (state_q)
          idle: begin
            idx <= '0;
            if (op_known) begin
              cmd_op <= esp_cmd_t'(rx_byte);
              if (op_nparams != '0) begin
                bytes_left <= op_nparams;
                state_q    <= read_bytes;
              end else begin
                cmd_strobe <= 1'b1;       // fire right away
                reply_load <= op_replies;
              end
            end
          end
          read_bytes: begin
            idx <= idx + CNT_W'(1);
            if (bytes_left == CNT_W'(1)) begin
              cmd_strobe <= 1'b1; // last parameter in
              state_q    <= idle;
            end else begin
              bytes_left <= bytes_left - CNT_W'(1);
            end
          end
          default: begin
            state_q <= idle;
          end
        endcase
      end
    end
  end

  assign take_param = rx_valid && (state_q == read_bytes);
  assign take_reply = rx_valid && (state_q == idle) && op_replies;

  // parameter store and reply register
  always_ff @(posedge clk) begin
    if (take_param) begin
      params[idx] <= rx_byte;
    end
    if (take_reply) begin
      reply_byte <= reply_next;
    end
  end

  assign p0 = params[0]; // slot
  assign p1 = params[1]; // address low
  assign p2 = params[2]; // address high

endmodule

`default_nettype wire

// ==== spi_byte_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_byte_slave (
  input  logic       clk,
  input  logic       rst_button,
  input  logic       cs_n,
  input  logic       sck,
  input  logic       mosi,
  output logic       miso,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  input  logic [7:0] reply_byte,
  input  logic       reply_load
);

  logic [2:0] sck_sync;   // bit 2 is the oldest sample
  logic [2:0] cs_sync;
  logic [2:0] mosi_sync;
  logic       cs_active;
  logic       sck_rise;
  logic       sck_fall;
  logic [2:0] bit_cnt;    // bit position in current byte
  logic [7:0] tx_shift;   // msb is on miso
  logic [3:0] tx_left;    // falling edges left in reply frame
  logic       tx_started; // reply frame has begun
  logic       tx_pending;

  // pin synchronisers
  always_ff @(posedge clk or posedge rst_button) begin
    if (rst_button) begin
      sck_sync  <= '0;
      cs_sync   <= '1; // deselected
      mosi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[1:0], cs_n};
      mosi_sync <= {mosi_sync[1:0], mosi};
    end
  end

  assign cs_active  = ~cs_sync[2];
  assign sck_rise   = cs_active && (sck_sync[2:1] == 2'b01);
  assign sck_fall   = cs_active && (sck_sync[2:1] == 2'b10);
  assign tx_pending = (tx_left != 4'd0);

  // bit counter and byte-complete pulse
  always_ff @(posedge clk or posedge rst_button) begin
    if (rst_button) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0; // realign on every select
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        // dummy bytes clocking out a reply never reach the parser
        if ((bit_cnt == 3'd7) && !tx_pending) begin
          rx_valid <= 1'b1;
        end
      end
    end
  end

  // receive shift, msb first
  // mosi_sync[2] is the last low-phase sample, host holds it from the previous fall
  always_ff @(posedge clk) begin
    if (sck_rise) begin
      rx_byte <= {rx_byte[6:0], mosi_sync[2]};
    end
  end

  // reply shifter
  always_ff @(posedge clk or posedge rst_button) begin
    if (rst_button) begin
      tx_shift   <= '0;
      tx_left    <= '0;
      tx_started <= 1'b0;
    end else if (reply_load) begin
      tx_shift   <= reply_byte; // bit 7 out at once
      tx_left    <= 4'd8;
      tx_started <= 1'b0;       // a newer reply replaces an unsent one
    end else if (tx_pending) begin
      // trailing fall of the command byte must not shift
      if (sck_rise) begin
        tx_started <= 1'b1;
      end
      if (sck_fall && tx_started) begin
        tx_shift <= {tx_shift[6:0], 1'b0};
        tx_left  <= tx_left - 4'd1; // eighth fall ends the reply
      end
    end
  end

  // raw cs_n so miso drops the moment the host deselects
  assign miso = !cs_n && tx_shift[7];

endmodule

`default_nettype wire

// ==== esp_link_pkg.sv ====
`default_nettype none

package esp_link_pkg;

  // command parser states
  typedef enum logic [1:0] {
    idle       = 2'd0, // waiting for an opcode
    read_bytes = 2'd1  // collecting parameter bytes
  } parser_state_t;

  // host opcodes, values match the wifi side firmware
  typedef enum logic [7:0] {
    get_cookie          = 8'd0,  // reply af
    set_breakpoint      = 8'd6,  // slot, addr lo, addr hi
    clear_breakpoint    = 8'd7,  // slot
    enable_breakpoints  = 8'd11,
    disable_breakpoints = 8'd12,
    xray_resume         = 8'd13, // leave stop
    get_version         = 8'd15, // reply {major, minor}
    abus_read           = 8'd18  // reply bus address low byte
  } esp_cmd_t;

  // breakpoint run/stop state
  typedef enum logic {
    xray_run  = 1'b0,
    xray_stop = 1'b1
  } xray_state_t;

endpackage

`default_nettype wire

// ==== esp_link_defs.svh ====
`ifndef ESP_LINK_DEFS_SVH
`define ESP_LINK_DEFS_SVH

// identification byte, host checks it after link-up
`define ESP_COOKIE 8'haf

// version reply byte is {major, minor}
`define VERSION_MAJOR 3'd0
`define VERSION_MINOR 5'd3

// breakpoint table size
`define NUM_BREAKPOINTS 8
`define BP_IDX_W 3 // slot number width

// set_breakpoint is the longest command: slot, addr lo, addr hi
`define MAX_PARAMS 3

`endif
